/* design/memPkg.sv */
package memPkg;

    // Address and data widths fixed by RV32I
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // Address fields for the two-way cache and the backing memory
    typedef logic [27:0] tag_t;     // Address bits 31 to 4
    typedef logic [1:0]  setIdx_t;  // Address bits 3 to 2
    typedef logic [7:0]  memIdx_t;  // Address bits 9 to 2

    localparam int NumSets  = 4;
    localparam int MemWords = 256;

    // Single uncached location
    localparam addr_t MmioAddr = 32'h0000_00FC;

    // One way of one set
    typedef struct packed {
        logic  valid;
        logic  dirty;
        tag_t  tag;
        word_t data;
    } wayEntry_t;

    // One write into the backing memory
    typedef struct packed {
        logic    en;
        memIdx_t addr;
        word_t   data;
    } memWrite_t;

endpackage

/* design/lsuPkg.sv */
package lsuPkg;

    // Load/store width, encoded as the funct3 field
    typedef enum logic [2:0] {
        Byte  = 3'b000,  // lb / sb
        Half  = 3'b001,  // lh / sh
        Word  = 3'b010,  // lw / sw
        ByteU = 3'b100,  // lbu
        HalfU = 3'b101   // lhu
    } accessWidth_t;

    // Pipeline request, held steady while stall is high
    typedef struct packed {
        logic          read;
        logic          write;
        accessWidth_t  width;
        memPkg::addr_t addr;
        memPkg::word_t storeData;
    } cpuReq_t;

endpackage

/* design/loadAlign.sv */
`timescale 1ns/1ns

module loadAlign (
    input  memPkg::word_t        word,
    input  lsuPkg::accessWidth_t width,
    input  logic [1:0]           offset,
    input  logic                 en,
    output memPkg::word_t        loadData
);

    logic [7:0]  selByte;
    logic [15:0] selHalf;

    // Byte lane and half lane picked by the low address bits
    always_comb begin
        selByte = word[{offset, 3'b000} +: 8];
        selHalf = offset[1] ? word[31:16] : word[15:0];
    end

    always_comb begin
        loadData = '0;
        if (en) begin
            case (width)
                lsuPkg::Byte: begin
                    loadData = {{24{selByte[7]}}, selByte};   // Sign extended
                end
                lsuPkg::Half: begin
                    loadData = {{16{selHalf[15]}}, selHalf};
                end
                lsuPkg::Word: begin
                    loadData = word;
                end
                lsuPkg::ByteU: begin
                    loadData = {24'b0, selByte};              // Zero extended
                end
                lsuPkg::HalfU: begin
                    loadData = {16'b0, selHalf};
                end
                default: begin
                    loadData = '0;
                end
            endcase
        end
    end

endmodule

/* design/storeMerge.sv */
`timescale 1ns/1ns

module storeMerge (
    input  memPkg::word_t        oldWord,
    input  memPkg::word_t        storeData,
    input  lsuPkg::accessWidth_t width,
    input  logic [1:0]           offset,
    output memPkg::word_t        mergedWord
);

    // Only the addressed lanes change, the rest keep the old word
    always_comb begin
        mergedWord = oldWord;
        case (width)
            lsuPkg::Byte: begin
                mergedWord[{offset, 3'b000} +: 8] = storeData[7:0];
            end
            lsuPkg::Half: begin
                if (offset[1]) begin
                    mergedWord[31:16] = storeData[15:0];  // Upper half
                end else begin
                    mergedWord[15:0] = storeData[15:0];
                end
            end
            lsuPkg::Word: begin
                mergedWord = storeData;
            end
            default: begin
                // No unsigned stores in RV32I
                mergedWord = oldWord;
            end
        endcase
    end

endmodule

/* design/dataMemory.sv */
`timescale 1ns/1ns

module dataMemory (
    input  logic              clk,
    input  memPkg::memIdx_t   rdIdx,
    input  memPkg::memWrite_t wr,
    output memPkg::word_t     rdData
);

    memPkg::word_t mem [memPkg::MemWords];

    // Contents start cleared
    initial begin
        for (int i = 0; i < memPkg::MemWords; i++) begin
            mem[i] = '0;
        end
    end

    // Combinational read, the cache registers the fetch itself
    assign rdData = mem[rdIdx];

    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;  // Writeback or MMIO store
        end
    end

endmodule

/* design/setAssocCache.sv */
`timescale 1ns/1ns

module setAssocCache (
    input  logic              clk,
    input  logic              rst,
    input  lsuPkg::cpuReq_t   req,
    input  memPkg::word_t     memRdData,
    input  memPkg::word_t     mergedWord,
    output memPkg::word_t     hitWord,
    output logic              hit,
    output logic              stall,
    output logic              mmioWrite,
    output memPkg::memIdx_t   memRdIdx,
    output memPkg::memWrite_t memWr,
    output memPkg::word_t     mmioData
);

    // Way 0 and way 1 entries, indexed by set
    memPkg::wayEntry_t ways [2][memPkg::NumSets];

    // Per-set LRU bit naming the next victim way
    logic [memPkg::NumSets-1:0] lru;

    memPkg::tag_t      reqTag;
    memPkg::setIdx_t   reqSet;
    logic              isMmio;
    logic              access;     // Cacheable load or store
    logic [1:0]        wayMatch;
    logic              hitWay;
    logic              victimWay;
    memPkg::wayEntry_t victim;
    logic              missCycle;  // First stall cycle of a miss
    logic              fetch;      // Second stall cycle, refill pending

    assign reqTag = req.addr[31:4];
    assign reqSet = req.addr[3:2];
    assign isMmio = (req.addr == memPkg::MmioAddr);
    assign access = (req.read || req.write) && !isMmio;

    // Tag compare in both ways
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            wayMatch[w] = ways[w][reqSet].valid && (ways[w][reqSet].tag == reqTag);
        end
    end

    assign hitWay = wayMatch[1];  // A tag is never resident in both ways
    assign hit    = access && (|wayMatch);
    assign stall  = access && !(|wayMatch);

    always_comb begin
        hitWord = '0;
        if (hit) begin
            hitWord = ways[hitWay][reqSet].data;
        end
    end

    assign victimWay = lru[reqSet];
    assign victim    = ways[victimWay][reqSet];
    assign missCycle = stall && !fetch;

    // Requested word is read in both stall cycles and on MMIO
    assign memRdIdx = req.addr[9:2];

    // Dirty victim goes back to memory at the end of the miss cycle
    always_comb begin
        memWr.en   = missCycle && victim.valid && victim.dirty;
        memWr.addr = {victim.tag[5:0], reqSet};
        memWr.data = victim.data;
    end

    // MMIO handled by the top level and memory
    assign mmioWrite = req.write && isMmio;
    assign mmioData  = isMmio ? memRdData : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fetch <= 1'b0;
        end else begin
            fetch <= missCycle;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lru <= '0;
            for (int s = 0; s < memPkg::NumSets; s++) begin
                for (int w = 0; w < 2; w++) begin
                    ways[w][s].valid <= 1'b0;
                    ways[w][s].dirty <= 1'b0;
                end
            end
        end else if (fetch) begin
            // Refill the victim with the word read during this cycle
            ways[victimWay][reqSet].valid <= 1'b1;
            ways[victimWay][reqSet].dirty <= 1'b0;
            ways[victimWay][reqSet].tag   <= reqTag;
            ways[victimWay][reqSet].data  <= memRdData;
            lru[reqSet]                   <= ~victimWay;
        end else if (hit) begin
            lru[reqSet] <= ~hitWay;
            if (req.write) begin
                ways[hitWay][reqSet].data  <= mergedWord;  // Memory updated only on eviction
                ways[hitWay][reqSet].dirty <= 1'b1;
            end
        end
    end

    // Refill cycle never looks like a hit
    hitDuringFetch : assert property (
        @(posedge clk) disable iff (rst) !(hit && fetch)
    ) else $error("hit high during refill cycle");

    // No writeback or MMIO store while the refill uses the memory port
    noWriteInFetch : assert property (
        @(posedge clk) disable iff (rst) fetch |-> !memWr.en && !mmioWrite
    ) else $error("memory write during refill cycle");

    // Uncached address never waits on a miss or a refill
    mmioNoStall : assert property (
        @(posedge clk) disable iff (rst) isMmio |-> !stall && !fetch
    ) else $error("stall or refill pending on MMIO access");

endmodule

/* design/cacheSubsys.sv */
`timescale 1ns/1ns

module cacheSubsys (
    input  logic            clk,
    input  logic            rst,
    input  lsuPkg::cpuReq_t req,
    output memPkg::word_t   loadData,
    output logic            stall,
    output logic            hit
);

    memPkg::word_t     hitWord;
    memPkg::word_t     mmioData;
    memPkg::word_t     accessWord;
    memPkg::word_t     mergedWord;
    memPkg::word_t     memRdData;
    memPkg::memIdx_t   memRdIdx;
    memPkg::memWrite_t cacheWr;
    memPkg::memWrite_t memWr;
    logic              mmioWrite;

    setAssocCache cache_i (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .memRdData  (memRdData),
        .mergedWord (mergedWord),
        .hitWord    (hitWord),
        .hit        (hit),
        .stall      (stall),
        .mmioWrite  (mmioWrite),
        .memRdIdx   (memRdIdx),
        .memWr      (cacheWr),
        .mmioData   (mmioData)
    );

    // Hit line for cached accesses, memory word for MMIO
    assign accessWord = hit ? hitWord : mmioData;

    loadAlign align_i (
        .word     (accessWord),
        .width    (req.width),
        .offset   (req.addr[1:0]),
        .en       (req.read && !stall),  // Cached hit or MMIO read
        .loadData (loadData)
    );

    storeMerge merge_i (
        .oldWord    (accessWord),
        .storeData  (req.storeData),
        .width      (req.width),
        .offset     (req.addr[1:0]),
        .mergedWord (mergedWord)
    );

    // MMIO store goes straight to memory, never overlaps a writeback
    always_comb begin
        memWr = cacheWr;
        if (mmioWrite) begin
            memWr.en   = 1'b1;
            memWr.addr = memRdIdx;
            memWr.data = mergedWord;
        end
    end

    dataMemory memory_i (
        .clk    (clk),
        .rdIdx  (memRdIdx),
        .wr     (memWr),
        .rdData (memRdData)
    );

endmodule

/* bench/cacheSubsysTb.sv */
`timescale 1ns/1ns

module cacheSubsysTb;

    localparam int ResetCycles  = 8;
    localparam int MarginCycles = 20;
    localparam int DriveDelay   = 5;

    // One table row: a load or a store
    typedef struct packed {
        logic                 isWrite;
        lsuPkg::accessWidth_t width;
        memPkg::addr_t        addr;
        memPkg::word_t        data;
    } stimEntry_t;

    logic            clk;
    logic            rst;
    lsuPkg::cpuReq_t req;
    memPkg::word_t   loadData;
    logic            stall;
    logic            hit;

    stimEntry_t stimTable [$];
    integer     seed = 32'h5da1_5770;
    int         cycleCount = 0;
    int         cycleLimit;

    // Reference model of memory and cache tags
    memPkg::word_t modelMem   [memPkg::MemWords];
    memPkg::tag_t  modelTag   [2][memPkg::NumSets];
    memPkg::word_t modelData  [2][memPkg::NumSets];
    logic          modelValid [2][memPkg::NumSets];
    logic          modelDirty [2][memPkg::NumSets];
    logic          modelLru   [memPkg::NumSets];

    cacheSubsys dut_i (
        .clk      (clk),
        .rst      (rst),
        .req      (req),
        .loadData (loadData),
        .stall    (stall),
        .hit      (hit)
    );

    always #50 clk = ~clk;

    // Run limit watchdog
    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("ERROR: simulation timed out after %0d clock cycles", cycleCount);
            $display("FAIL: see errors above");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERROR: time %0t ns, %s = 0x%08h, expected 0x%08h",
                     $time, name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // Lane picked by shifting the whole word down
    function automatic memPkg::word_t extendLoad(input memPkg::word_t w,
                                                 input lsuPkg::accessWidth_t width,
                                                 input logic [1:0] off);
        memPkg::word_t b;
        memPkg::word_t h;
        b = (w >> (8 * int'(off))) & 32'h0000_00FF;
        h = (w >> (16 * int'(off[1]))) & 32'h0000_FFFF;
        case (width)
            lsuPkg::Byte:  return b[7] ? (b | 32'hFFFF_FF00) : b;
            lsuPkg::Half:  return h[15] ? (h | 32'hFFFF_0000) : h;
            lsuPkg::Word:  return w;
            lsuPkg::ByteU: return b;
            lsuPkg::HalfU: return h;
            default:       return '0;
        endcase
    endfunction

    // Mask and shift form of a store into a word
    function automatic memPkg::word_t mergeStore(input memPkg::word_t old,
                                                 input memPkg::word_t sd,
                                                 input lsuPkg::accessWidth_t width,
                                                 input logic [1:0] off);
        memPkg::word_t mask;
        int            shiftAmt;
        mask     = '0;
        shiftAmt = 0;
        if (width == lsuPkg::Byte) begin
            shiftAmt = 8 * int'(off);
            mask     = 32'h0000_00FF << shiftAmt;
        end else if (width == lsuPkg::Half) begin
            shiftAmt = 16 * int'(off[1]);
            mask     = 32'h0000_FFFF << shiftAmt;
        end else if (width == lsuPkg::Word) begin
            mask = 32'hFFFF_FFFF;
        end
        return (old & ~mask) | ((sd << shiftAmt) & mask);
    endfunction

    task automatic initModel();
        for (int i = 0; i < memPkg::MemWords; i++) begin
            modelMem[i] = '0;
        end
        for (int s = 0; s < memPkg::NumSets; s++) begin
            modelLru[s] = 1'b0;
            for (int w = 0; w < 2; w++) begin
                modelValid[w][s] = 1'b0;
                modelDirty[w][s] = 1'b0;
                modelTag[w][s]   = '0;
                modelData[w][s]  = '0;
            end
        end
    endtask

    // Predicts stall length and load data, then updates the model
    task automatic modelAccess(input stimEntry_t e, output int expStall,
                               output logic expFirstHit, output memPkg::word_t expLoad);
        memPkg::setIdx_t s;
        memPkg::tag_t    t;
        memPkg::memIdx_t idx;
        logic [1:0]      off;
        int              way;
        memPkg::addr_t   victimAddr;
        s        = e.addr[3:2];
        t        = e.addr[31:4];
        idx      = e.addr[9:2];
        off      = e.addr[1:0];
        expStall = 0;
        expLoad  = '0;
        way      = -1;
        if (e.addr == memPkg::MmioAddr) begin
            expFirstHit = 1'b0;  // Uncached, memory word used directly
            if (e.isWrite) begin
                modelMem[idx] = mergeStore(modelMem[idx], e.data, e.width, off);
            end else begin
                expLoad = extendLoad(modelMem[idx], e.width, off);
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (modelValid[w][s] && modelTag[w][s] == t) begin
                    way = w;
                end
            end
            expFirstHit = (way >= 0);
            if (way < 0) begin
                way      = modelLru[s];
                expStall = 2;
                if (modelValid[way][s] && modelDirty[way][s]) begin
                    victimAddr = {modelTag[way][s], s, 2'b00};
                    modelMem[victimAddr[9:2]] = modelData[way][s];  // Writeback
                end
                modelValid[way][s] = 1'b1;
                modelDirty[way][s] = 1'b0;
                modelTag[way][s]   = t;
                modelData[way][s]  = modelMem[idx];
            end
            modelLru[s] = (way == 0);
            if (e.isWrite) begin
                modelData[way][s]  = mergeStore(modelData[way][s], e.data, e.width, off);
                modelDirty[way][s] = 1'b1;
            end else begin
                expLoad = extendLoad(modelData[way][s], e.width, off);
            end
        end
    endtask

    task automatic addEntry(input logic isWrite, input lsuPkg::accessWidth_t width,
                            input memPkg::addr_t addr, input memPkg::word_t data);
        stimEntry_t e;
        e.isWrite = isWrite;
        e.width   = width;
        e.addr    = addr;
        e.data    = data;
        stimTable.push_back(e);
    endtask

    // All five load widths at every byte of one word
    task automatic addLoadSweep(input memPkg::addr_t base);
        lsuPkg::accessWidth_t loadWidths [5];
        loadWidths = '{lsuPkg::Byte, lsuPkg::Half, lsuPkg::Word, lsuPkg::ByteU, lsuPkg::HalfU};
        for (int o = 0; o < 4; o++) begin
            for (int w = 0; w < 5; w++) begin
                addEntry(1'b0, loadWidths[w], base + o, '0);
            end
        end
    endtask

    task automatic buildTable();
        // Cold miss then hit on zeroed memory
        addEntry(1'b0, lsuPkg::Word, 32'h100, '0);
        addEntry(1'b0, lsuPkg::Word, 32'h100, '0);
        // Merging by width and offset
        addEntry(1'b1, lsuPkg::Word, 32'h104, 32'h80FF_7F01);
        addLoadSweep(32'h104);
        addEntry(1'b1, lsuPkg::Half, 32'h106, $random(seed));
        addEntry(1'b1, lsuPkg::Byte, 32'h105, $random(seed));
        addLoadSweep(32'h104);
        addEntry(1'b1, lsuPkg::Half, 32'h104, 32'h0000_8001);
        addEntry(1'b1, lsuPkg::Byte, 32'h107, 32'h0000_007E);
        addLoadSweep(32'h104);
        // Set 2 eviction with dirty writeback
        addEntry(1'b1, lsuPkg::Word, 32'h008, $random(seed));
        addEntry(1'b1, lsuPkg::Word, 32'h018, $random(seed));
        addEntry(1'b0, lsuPkg::Word, 32'h008, '0);
        addEntry(1'b0, lsuPkg::Word, 32'h018, '0);
        addEntry(1'b0, lsuPkg::Word, 32'h028, '0);
        addEntry(1'b0, lsuPkg::Word, 32'h008, '0);
        addEntry(1'b0, lsuPkg::Word, 32'h018, '0);
        // Set 3, hit on one way steers the victim
        addEntry(1'b0, lsuPkg::Word, 32'h00C, '0);
        addEntry(1'b1, lsuPkg::Word, 32'h01C, $random(seed));
        addEntry(1'b0, lsuPkg::Word, 32'h00C, '0);
        addEntry(1'b1, lsuPkg::Word, 32'h02C, $random(seed));
        addEntry(1'b0, lsuPkg::Word, 32'h00C, '0);
        addEntry(1'b0, lsuPkg::Word, 32'h01C, '0);
        // MMIO word
        addEntry(1'b1, lsuPkg::Word, memPkg::MmioAddr, $random(seed));
        addEntry(1'b0, lsuPkg::Word, memPkg::MmioAddr, '0);
        addEntry(1'b0, lsuPkg::Byte, memPkg::MmioAddr, '0);
        addEntry(1'b0, lsuPkg::ByteU, memPkg::MmioAddr, '0);
        addEntry(1'b0, lsuPkg::Half, memPkg::MmioAddr, '0);
        addEntry(1'b0, lsuPkg::HalfU, memPkg::MmioAddr, '0);
        addEntry(1'b1, lsuPkg::Byte, memPkg::MmioAddr, 32'h0000_00A5);
        addEntry(1'b0, lsuPkg::Word, memPkg::MmioAddr, '0);
        addEntry(1'b1, lsuPkg::Half, memPkg::MmioAddr, 32'h0000_F00D);
        addEntry(1'b0, lsuPkg::Half, memPkg::MmioAddr, '0);
        // Cached lines still intact
        addEntry(1'b0, lsuPkg::Word, 32'h00C, '0);
        addEntry(1'b0, lsuPkg::Word, 32'h02C, '0);
        addEntry(1'b0, lsuPkg::Word, 32'h104, '0);
    endtask

    // Entered and left 5 ns after a rising edge
    task automatic applyEntry(input stimEntry_t e);
        int            expStall;
        logic          expFirstHit;
        memPkg::word_t expLoad;
        int            stallCycles;
        logic          cached;
        modelAccess(e, expStall, expFirstHit, expLoad);
        cached        = (e.addr != memPkg::MmioAddr);
        req.read      = !e.isWrite;
        req.write     = e.isWrite;
        req.width     = e.width;
        req.addr      = e.addr;
        req.storeData = e.data;
        stallCycles   = 0;
        @(negedge clk);
        checkValue("hit (first cycle)", {31'b0, hit}, {31'b0, expFirstHit});
        while (stall) begin
            stallCycles = stallCycles + 1;
            @(negedge clk);
        end
        checkValue("stall cycles", stallCycles, expStall);
        checkValue("hit", {31'b0, hit}, {31'b0, cached});
        if (!e.isWrite) begin
            checkValue("loadData", loadData, expLoad);
        end
        @(posedge clk);
        #DriveDelay;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        initModel();
        buildTable();
        cycleLimit = 3 * stimTable.size() + ResetCycles + MarginCycles;
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        rst = 1'b0;
        @(negedge clk);
        checkValue("stall", {31'b0, stall}, 32'd0);
        checkValue("hit", {31'b0, hit}, 32'd0);
        @(posedge clk);
        #DriveDelay;
        foreach (stimTable[i]) begin
            applyEntry(stimTable[i]);
        end
        req = '0;
        @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

/* cacheSubsys.f */
design/memPkg.sv
design/lsuPkg.sv
design/loadAlign.sv
design/storeMerge.sv
design/dataMemory.sv
design/setAssocCache.sv
design/cacheSubsys.sv
bench/cacheSubsysTb.sv
